// ==== exec_types_pkg.sv ====
// Data widths of the execute stage, fixed by RV32
// Word and double-word vectors are plain unsigned logic
`default_nettype none

package exec_types_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int XLEN     = 32;  // One machine word
  localparam int MD_STEPS = 32;  // Mul/div iterations, one per operand bit

  // Operand or result word
  typedef logic [XLEN-1:0]   word_t;

  // Mul/div result, low word in [31:0], high word in [63:32]
  typedef logic [2*XLEN-1:0] dword_t;

  // Step counter, wide enough for MD_STEPS
  typedef logic [5:0]        step_t;

endpackage

`default_nettype wire

// ==== exec_ops_pkg.sv ====
// Function codes of the ALU and of the mul/div unit
// Top-level fn_t holds either code, mul/div codes in the low 3 bits
`default_nettype none

package exec_ops_pkg;

  // ------------------------------
  // ALU functions
  // ------------------------------
  typedef logic [3:0] alu_fn_t;

  localparam alu_fn_t ALU_ADD = 4'd0;
  localparam alu_fn_t ALU_SUB = 4'd1;
  localparam alu_fn_t ALU_SLL = 4'd2;
  localparam alu_fn_t ALU_OR  = 4'd3;
  localparam alu_fn_t ALU_LT  = 4'd4;   // Signed compare
  localparam alu_fn_t ALU_LTU = 4'd5;   // Unsigned compare
  localparam alu_fn_t ALU_AND = 4'd6;
  localparam alu_fn_t ALU_XOR = 4'd7;
  localparam alu_fn_t ALU_NOR = 4'd8;
  localparam alu_fn_t ALU_SRL = 4'd9;
  localparam alu_fn_t ALU_SRA = 4'd10;

  // ------------------------------
  // Mul/div functions
  // ------------------------------
  typedef logic [2:0] md_fn_t;

  localparam md_fn_t MD_MUL  = 3'd0;  // Low word of product
  localparam md_fn_t MD_DIV  = 3'd1;
  localparam md_fn_t MD_DIVU = 3'd2;
  localparam md_fn_t MD_REM  = 3'd3;  // Takes high word
  localparam md_fn_t MD_REMU = 3'd4;  // Takes high word

  // Top-level function code
  typedef logic [3:0] fn_t;

endpackage

`default_nettype wire

// ==== md_if.sv ====
// Mul/div request and response, val/rdy on each side
// Responder holds resp_val and resp_result until resp_rdy
`timescale 1ns/1ps
`default_nettype none

interface md_if
  import exec_types_pkg::*, exec_ops_pkg::*;
();

  logic   req_val;
  logic   req_rdy;
  md_fn_t req_fn;
  word_t  req_a;       // Dividend or multiplicand
  word_t  req_b;       // Divisor or multiplier
  logic   resp_val;
  logic   resp_rdy;
  dword_t resp_result; // {remainder, quotient} or product

  modport requester (output req_val, req_fn, req_a, req_b, resp_rdy,
                     input  req_rdy, resp_val, resp_result);

  modport responder (input  req_val, req_fn, req_a, req_b, resp_rdy,
                     output req_rdy, resp_val, resp_result);

endinterface

`default_nettype wire

// ==== exec_alu.sv ====
// Single-cycle integer ALU, purely combinational
// Shift amount is in1[4:0]; undefined codes give zero
`timescale 1ns/1ps
`default_nettype none

module exec_alu
  import exec_types_pkg::*, exec_ops_pkg::*;
(
  input  word_t   in0,
  input  word_t   in1,
  input  alu_fn_t fn,
  output word_t   out
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = in1[4:0];                   // RV32 shifts ignore upper bits
  assign lt_s  = $signed(in0) < $signed(in1);
  assign lt_u  = in0 < in1;

  // ------------------------------
  // Function select
  // ------------------------------
  always_comb begin
    case (fn)
      ALU_ADD: out = in0 + in1;
      ALU_SUB: out = in0 - in1;
      ALU_SLL: out = in0 << shamt;
      ALU_OR:  out = in0 | in1;
      ALU_LT:  out = {{(XLEN-1){1'b0}}, lt_s};  // 1 or 0
      ALU_LTU: out = {{(XLEN-1){1'b0}}, lt_u};
      ALU_AND: out = in0 & in1;
      ALU_XOR: out = in0 ^ in1;
      ALU_NOR: out = ~(in0 | in1);
      ALU_SRL: out = in0 >> shamt;             // Zero fill
      ALU_SRA: out = word_t'($signed(in0) >>> shamt);  // Sign fill
      default: out = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== exec_muldiv.sv ====
// Iterative mul/div, one request at a time, 32 steps plus handshake
// Works on magnitudes and fixes signs on the way out
// Div by zero gives q = all ones, r = dividend (RISC-V rules)
`timescale 1ns/1ps
`default_nettype none

module exec_muldiv
  import exec_types_pkg::*, exec_ops_pkg::*;
(
  input  logic clk,
  input  logic reset,
  md_if.responder md
);

  typedef enum logic [1:0] {IDLE, BUSY, DONE} md_state_e;

  md_state_e       state;
  step_t           cnt;
  dword_t          acc;        // {hi, lo} working register
  word_t           opnd;       // Addend for mul, divisor for div
  logic            is_mul;
  logic            neg_lo;     // Product sign for mul, quotient sign for div
  logic            neg_hi;     // Remainder sign
  logic            signed_fn;
  logic            sa, sb;
  word_t           a_mag, b_mag;
  logic            req_fire, resp_fire;
  logic [XLEN:0]   mul_sum;    // One carry bit
  logic [XLEN:0]   div_diff;   // Bit XLEN is the borrow
  dword_t          mul_next, div_next;

  assign req_fire  = md.req_val && md.req_rdy;
  assign resp_fire = md.resp_val && md.resp_rdy;

  // ------------------------------
  // Request decode
  // ------------------------------
  always_comb begin
    case (md.req_fn)
      MD_MUL, MD_DIV, MD_REM: signed_fn = 1'b1;
      MD_DIVU, MD_REMU:       signed_fn = 1'b0;
      default:                signed_fn = 1'b0;
    endcase
    sa    = signed_fn && md.req_a[XLEN-1];
    sb    = signed_fn && md.req_b[XLEN-1];
    a_mag = sa ? word_t'(-md.req_a) : md.req_a;  // 0x80000000 stays as is
    b_mag = sb ? word_t'(-md.req_b) : md.req_b;
  end

  // ------------------------------
  // One step of each algorithm
  // ------------------------------
  // Shift-add, multiplier sits in lo and drains out the bottom
  assign mul_sum  = {1'b0, acc[2*XLEN-1:XLEN]} + (acc[0] ? {1'b0, opnd} : '0);
  assign mul_next = {mul_sum, acc[XLEN-1:1]};

  // Restoring divide, trial subtract of the shifted partial remainder
  assign div_diff = {acc[2*XLEN-1:XLEN], acc[XLEN-1]} - {1'b0, opnd};
  assign div_next = div_diff[XLEN] ? {acc[2*XLEN-2:0], 1'b0}         // Restore
                                   : {div_diff[XLEN-1:0], acc[XLEN-2:0], 1'b1};

  // FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: if (req_fire) begin
          state <= BUSY;
          cnt   <= '0;
        end
        BUSY: begin
          cnt <= cnt + step_t'(1);
          if (cnt == step_t'(MD_STEPS - 1)) state <= DONE;
        end
        DONE: if (resp_fire) state <= IDLE;  // Held until taken
        default: state <= IDLE;
      endcase
    end
  end

  // Operand latch and iteration
  always_ff @(posedge clk) begin
    if (req_fire) begin
      is_mul <= (md.req_fn == MD_MUL);
      neg_hi <= sa;                          // Only read for div and rem
      // No quotient negate on /0, keeps all ones
      neg_lo <= (sa ^ sb) && ((md.req_fn == MD_MUL) || (md.req_b != '0));
      opnd   <= (md.req_fn == MD_MUL) ? a_mag : b_mag;
      acc    <= {word_t'(0), (md.req_fn == MD_MUL) ? b_mag : a_mag};
    end else if (state == BUSY) begin
      acc <= is_mul ? mul_next : div_next;
    end
  end

  // ------------------------------
  // Response with sign fix
  // ------------------------------
  assign md.req_rdy     = (state == IDLE);
  assign md.resp_val    = (state == DONE);
  assign md.resp_result = is_mul ? (neg_lo ? dword_t'(-acc) : acc)
                        : {neg_hi ? word_t'(-acc[2*XLEN-1:XLEN]) : acc[2*XLEN-1:XLEN],
                           neg_lo ? word_t'(-acc[XLEN-1:0])      : acc[XLEN-1:0]};

  a_resp_after_all_steps: assert property (@(posedge clk) disable iff (reset)
    md.resp_val |-> cnt == step_t'(MD_STEPS))
    else $error("mul/div response before all steps ran");

  a_req_starts_busy: assert property (@(posedge clk) disable iff (reset)
    req_fire |=> state == BUSY && !md.req_rdy)
    else $error("mul/div accepted a request outside idle");

endmodule

`default_nettype wire

// ==== exec_result_stage.sv ====
// Accepts one op per op_val & op_rdy, ALU or mul/div
// Only one mul/div in flight; op_rdy stays low until its result
`timescale 1ns/1ps
`default_nettype none

module exec_result_stage
  import exec_types_pkg::*, exec_ops_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  op_val,
  input  logic  op_is_md,
  input  fn_t   op_fn,
  input  word_t op_a,
  input  word_t op_b,
  input  word_t alu_out,
  md_if.requester md,
  output logic  op_rdy,
  output word_t result,
  output logic  result_val
);

  logic pending;   // Mul/div issued, response not yet back
  logic take_hi;   // rem/remu take the high word
  logic accept;
  logic alu_fire;
  logic md_fire;
  logic resp_fire;

  assign op_rdy    = !pending;
  assign accept    = op_val && op_rdy;
  assign alu_fire  = accept && !op_is_md;
  assign md_fire   = accept && op_is_md;
  assign resp_fire = md.resp_val && md.resp_rdy;

  // ------------------------------
  // Request side
  // ------------------------------
  assign md.req_val  = md_fire;       // Transfers in the accept cycle
  assign md.req_fn   = op_fn[2:0];
  assign md.req_a    = op_a;
  assign md.req_b    = op_b;
  assign md.resp_rdy = 1'b1;          // X-to-M register always takes it

  // Control
  always_ff @(posedge clk) begin
    if (reset) begin
      pending    <= 1'b0;
      result_val <= 1'b0;
    end else begin
      result_val <= alu_fire || resp_fire;  // One-cycle pulse
      if (md_fire)
        pending <= 1'b1;
      else if (resp_fire)
        pending <= 1'b0;
    end
  end

  // X-to-M result register
  always_ff @(posedge clk) begin
    if (md_fire)
      take_hi <= (op_fn[2:0] == MD_REM) || (op_fn[2:0] == MD_REMU);
    if (alu_fire)
      result <= alu_out;
    else if (resp_fire)
      result <= take_hi ? md.resp_result[2*XLEN-1:XLEN] : md.resp_result[XLEN-1:0];
  end

  a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
    md.req_val |-> md.req_rdy)
    else $error("mul/div request while one is pending");

  a_resp_when_pending: assert property (@(posedge clk) disable iff (reset)
    md.resp_val |-> pending)
    else $error("mul/div response with nothing pending");

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
// Execute stage top, ALU and mul/div side by side
// op_val is ignored while op_rdy is low; hold the op and retry
`timescale 1ns/1ps
`default_nettype none

module exec_unit
  import exec_types_pkg::*, exec_ops_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  op_val,      // One-cycle strobe
  input  logic  op_is_md,
  input  fn_t   op_fn,
  input  word_t op_a,
  input  word_t op_b,
  output logic  op_rdy,      // Level
  output word_t result,
  output logic  result_val   // One-cycle pulse
);

  word_t alu_out;

  md_if i_md ();

  exec_alu i_alu (
    .in0 (op_a),
    .in1 (op_b),
    .fn  (op_fn),            // Low four bits are the ALU code
    .out (alu_out)
  );

  exec_muldiv i_muldiv (
    .clk   (clk),
    .reset (reset),
    .md    (i_md)
  );

  exec_result_stage i_result (
    .clk (clk), .reset (reset),
    .op_val (op_val), .op_is_md (op_is_md), .op_fn (op_fn),
    .op_a (op_a), .op_b (op_b), .alu_out (alu_out), .md (i_md),
    .op_rdy (op_rdy), .result (result), .result_val (result_val)
  );

endmodule

`default_nettype wire

// ==== tb_exec_unit.sv ====
// Self-checking testbench for the execute stage top
// Reads ops and expected results from exec_stim.txt in the project root
// then runs a block of random ALU ops checked against an ALU model
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit
  import exec_types_pkg::*, exec_ops_pkg::*;
();

  localparam int N_RAND        = 40;  // Random ALU ops after the stim file
  localparam int CYCLES_PER_OP = 60;  // Watchdog budget, mul/div needs ~36

  logic  clk;
  logic  reset;
  logic  op_val;
  logic  op_is_md;
  fn_t   op_fn;
  word_t op_a;
  word_t op_b;
  logic  op_rdy;
  word_t result;
  logic  result_val;

  // Stim file contents
  bit    stim_md[$];
  fn_t   stim_fn[$];
  word_t stim_a[$];
  word_t stim_b[$];
  word_t stim_exp[$];
  bit    stim_loaded = 1'b0;

  int     value_errs = 0;
  int     other_errs = 0;
  integer seed;

  exec_unit i_exec_unit (
    .clk (clk), .reset (reset),
    .op_val (op_val), .op_is_md (op_is_md), .op_fn (op_fn),
    .op_a (op_a), .op_b (op_b),
    .op_rdy (op_rdy), .result (result), .result_val (result_val)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // ------------------------------
  // Compare tasks and ALU model
  // ------------------------------
  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  function automatic word_t alu_model(input alu_fn_t fn, input word_t a, input word_t b);
    int    sh;
    word_t fill;
    sh   = b % 32;                                   // Low five bits only
    fill = a[31] ? ~(32'hffffffff >> sh) : '0;       // Sign bits for sra
    case (fn)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_SLL: return a << sh;
      ALU_OR:  return a | b;
      ALU_LT:  return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
      ALU_LTU: return word_t'(a < b);
      ALU_AND: return a & b;
      ALU_XOR: return a ^ b;
      ALU_NOR: return ~(a | b);
      ALU_SRL: return a >> sh;
      ALU_SRA: return (a >> sh) | fill;
      default: return '0;
    endcase
  endfunction

  // Sample and drive 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic load_stim(output bit ok);
    int    fd;
    int    got;
    int    kind;
    string line;
    fn_t   fn;
    word_t a;
    word_t b;
    word_t e;
    ok = 1'b0;
    fd = $fopen("exec_stim.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd)) begin
      got = $fgets(line, fd);
      if (got > 1 && line[0] != "#") begin  // Skip blank and comment lines
        if ($sscanf(line, "%h %h %h %h %h", kind, fn, a, b, e) == 5) begin
          stim_md.push_back(kind != 0);
          stim_fn.push_back(fn);
          stim_a.push_back(a);
          stim_b.push_back(b);
          stim_exp.push_back(e);
        end
      end
    end
    $fclose(fd);
    ok = (stim_md.size() > 0);
  endtask

  // One op from issue to result, with latency and handshake checks
  task automatic run_op(input bit is_md, input fn_t fn, input word_t a, input word_t b,
                        input word_t exp);
    int lat;
    while (!op_rdy) next_cycle();                    // Hold until ready
    op_val   = 1'b1;
    op_is_md = is_md;
    op_fn    = fn;
    op_a     = a;
    op_b     = b;
    next_cycle();                                    // Accepted on this edge
    op_val = 1'b0;
    lat    = 1;
    if (is_md) begin
      check_bit("op_rdy", op_rdy, 1'b0);             // Busy with mul/div
      op_val   = 1'b1;                               // Stray strobe, ignored
      op_is_md = 1'b0;
      op_fn    = ALU_ADD;
      op_a     = 32'h0000_1234;
      op_b     = 32'h0000_4321;
      next_cycle();
      op_val = 1'b0;
      lat    = 2;
    end
    while (!result_val) begin
      next_cycle();
      lat++;
      if (is_md && !result_val)
        check_bit("op_rdy", op_rdy, 1'b0);           // Still busy
    end
    check_word("result", result, exp);
    if (!is_md && lat != 1) begin
      other_errs++;
      $display("ALU result came %0d cycles after acceptance instead of 1 at %0t", lat, $time);
    end
    check_bit("op_rdy", op_rdy, 1'b1);               // Ready with the result
    next_cycle();
    check_bit("result_val", result_val, 1'b0);       // Single pulse, no extra result
  endtask

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial begin
    wait (stim_loaded);
    repeat ((stim_md.size() + N_RAND) * CYCLES_PER_OP + 10) @(posedge clk);
    $display("Timeout: the run did not finish in the cycles allowed for %0d ops",
             stim_md.size() + N_RAND);
    $display("SIMULATION FAILED");
    $finish;
  end

  // Main sequence
  initial begin
    bit    ok;
    fn_t   rfn;
    word_t ra;
    word_t rb;
    reset    = 1'b1;
    op_val   = 1'b0;
    op_is_md = 1'b0;
    op_fn    = '0;
    op_a     = '0;
    op_b     = '0;
    seed     = 32'hf4b22fc7;
    load_stim(ok);
    if (!ok) begin
      $display("Could not open exec_stim.txt or it holds no operations");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      stim_loaded = 1'b1;
      repeat (4) @(posedge clk);
      #1 reset = 1'b0;
      check_bit("op_rdy", op_rdy, 1'b1);
      check_bit("result_val", result_val, 1'b0);

      foreach (stim_md[i])
        run_op(stim_md[i], stim_fn[i], stim_a[i], stim_b[i], stim_exp[i]);

      for (int i = 0; i < N_RAND; i++) begin
        rfn = fn_t'({$random(seed)} % 11);
        ra  = $random(seed);
        rb  = $random(seed);
        run_op(1'b0, rfn, ra, rb, alu_model(alu_fn_t'(rfn), ra, rb));
      end

      $display("Errors: %0d wrong values, %0d wrong latencies", value_errs, other_errs);
      if (value_errs + other_errs == 0)
        $display("SIMULATION PASSED");
      else
        $display("SIMULATION FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== exec_stim.txt ====
# kind fn a b expected, all hex; kind 0 = ALU op, 1 = mul/div op
# fn is the ALU code (0 add .. a sra) or the mul/div code (0 mul .. 4 remu)
0 0 00000005 00000007 0000000c
0 1 00000003 00000005 fffffffe
0 2 00000003 00000024 00000030
0 3 f0f00000 0000f0f0 f0f0f0f0
0 4 ffffffff 00000001 00000001
0 5 ffffffff 00000001 00000000
0 6 ff00ff00 0ff00ff0 0f000f00
0 7 aaaaaaaa ffff0000 5555aaaa
0 8 0f0f0000 0000f0f0 f0f00f0f
0 9 80000000 00000004 08000000
0 a 80000000 00000004 f8000000
1 0 00000007 00000006 0000002a
1 0 fffffffd 00000005 fffffff1
1 0 fffffffe fffffffd 00000006
0 1 00000010 00000001 0000000f
1 1 fffffff9 00000002 fffffffd
1 2 fffffff9 00000002 7ffffffc
1 3 fffffff9 00000002 ffffffff
1 4 fffffff9 00000002 00000001
1 1 00000064 00000000 ffffffff
1 3 ffffff9c 00000000 ffffff9c
1 1 80000000 ffffffff 80000000
1 3 80000000 ffffffff 00000000
0 0 ffffffff 00000001 00000000

// ==== exec_unit.f ====
exec_types_pkg.sv
exec_ops_pkg.sv
md_if.sv
exec_alu.sv
exec_muldiv.sv
exec_result_stage.sv
exec_unit.sv
tb_exec_unit.sv
